// File: rtl/isa_pkg.sv
package isa_pkg;

    localparam int RegAddrW = 5;
    localparam int RegCount = 32;

    // instruction field positions
    localparam int OpLsb    = 26;
    localparam int OpW      = 6;
    localparam int RsLsb    = 21;
    localparam int RtLsb    = 16;
    localparam int RdLsb    = 11;
    localparam int ShamtLsb = 6;
    localparam int ShamtW   = 5;
    localparam int ImmW     = 16;
    localparam int FunctW   = 6;   // funct sits at bit 0

    typedef enum logic [OpW-1:0] {
        OpSpecial = 6'h00,
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0a,
        OpSltiu   = 6'h0b,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpXori    = 6'h0e,
        OpLui     = 6'h0f
    } opcode_e;

    typedef enum logic [FunctW-1:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2a,
        FnSltu = 6'h2b
    } funct_e;

endpackage

// File: rtl/pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluLui   // imm into upper half
    } aluOp_e;

    // operand source for the decode-stage forwarding mux
    typedef enum logic [1:0] {
        FwdRegfile,
        FwdExec,
        FwdWback
    } fwdSel_e;

endpackage

// File: rtl/stage_if.sv
// decoded bundle, decode -> execute
interface decExIf
    import isa_pkg::*, pipe_pkg::*;
();
    word_t               opA;
    word_t               opB;
    logic [ShamtW-1:0]   shamt;
    aluOp_e              aluOp;
    logic                regWrite;
    logic [RegAddrW-1:0] writeReg;
    word_t               pc;

    modport source (output opA, opB, shamt, aluOp, regWrite, writeReg, pc);
    modport sink   (input  opA, opB, shamt, aluOp, regWrite, writeReg, pc);
endinterface

interface exWbIf
    import isa_pkg::*, pipe_pkg::*;
();
    logic                regWrite;
    logic [RegAddrW-1:0] writeReg;
    word_t               result;
    word_t               pc;

    modport source (output regWrite, writeReg, result, pc);
    modport sink   (input  regWrite, writeReg, result, pc);
    modport fwd    (input  regWrite, writeReg, result);   // decode bypass from execute
endinterface

// writeback register contents, back to the register file
interface wbRfIf
    import isa_pkg::*, pipe_pkg::*;
();
    logic                regWrite;
    logic [RegAddrW-1:0] writeReg;
    word_t               result;
    word_t               pc;

    modport source (output regWrite, writeReg, result, pc);
    modport sink   (input  regWrite, writeReg, result);
endinterface

// File: rtl/fetch_stage.sv
module fetch_stage
    import pipe_pkg::*;
#(
    parameter word_t ResetPc = '0
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  stall_i,
    output word_t instAddr_o,
    output logic  instEn_o,
    output word_t pcF2_o,
    output logic  validF2_o
);

    word_t pc;

    assign instAddr_o = pc;
    assign instEn_o   = ~rst_i & ~stall_i;   // memory sees a fetch only when the pipe moves

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc        <= ResetPc;
            validF2_o <= 1'b0;
        end else if (!stall_i) begin
            pc        <= pc + 32'd4;
            validF2_o <= instEn_o;
        end
    end

    // address of the word that comes back next cycle
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcF2_o <= pc;
        end
    end

endmodule

// File: rtl/decode_stage.sv
module decode_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_i,
    input  logic   stall_i,
    input  word_t  instr_i,
    input  word_t  pcF2_i,
    input  logic   validF2_i,
    decExIf.source ex,
    exWbIf.fwd     fwdEx,
    wbRfIf.sink    wb
);

    word_t               instrD, pcD;
    word_t               regs [RegCount];
    word_t               rdA, rdB, srcA, srcB, immExt;
    opcode_e             opcode;
    funct_e              funct;
    logic [RegAddrW-1:0] rs, rt, rd, dest;
    logic [ImmW-1:0]     imm;
    fwdSel_e             selA, selB;
    aluOp_e              aluOp;
    logic                known, useImm, signExt, destRt;

    function automatic fwdSel_e pickFwd(input logic [RegAddrW-1:0] src,
                                        input logic exWe, input logic [RegAddrW-1:0] exDst,
                                        input logic wbWe, input logic [RegAddrW-1:0] wbDst);
        if (exWe && exDst == src) return FwdExec;   // youngest producer wins
        if (wbWe && wbDst == src) return FwdWback;
        return FwdRegfile;
    endfunction

    function automatic word_t fwdMux(input fwdSel_e sel, input word_t rfData,
                                     input word_t exData, input word_t wbData);
        case (sel)
            FwdExec:  return exData;
            FwdWback: return wbData;
            default:  return rfData;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            instrD <= '0;   // all-zero word is sll r0, a no-op
        end else if (!stall_i) begin
            instrD <= validF2_i ? instr_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcD <= pcF2_i;
        end
    end

    assign opcode = opcode_e'(instrD[OpLsb +: OpW]);
    assign funct  = funct_e'(instrD[FunctW-1:0]);
    assign rs     = instrD[RsLsb +: RegAddrW];
    assign rt     = instrD[RtLsb +: RegAddrW];
    assign rd     = instrD[RdLsb +: RegAddrW];
    assign imm    = instrD[ImmW-1:0];

    always_comb begin
        aluOp   = AluAdd;
        known   = 1'b1;
        useImm  = 1'b1;
        signExt = 1'b0;
        destRt  = 1'b1;
        case (opcode)
            OpSpecial: begin
                useImm = 1'b0;
                destRt = 1'b0;
                case (funct)
                    FnSll:   aluOp = AluSll;
                    FnSrl:   aluOp = AluSrl;
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnNor:   aluOp = AluNor;
                    FnSlt:   aluOp = AluSlt;
                    FnSltu:  aluOp = AluSltu;
                    default: known = 1'b0;
                endcase
            end
            OpAddiu: begin
                aluOp   = AluAdd;
                signExt = 1'b1;
            end
            OpSlti: begin
                aluOp   = AluSlt;
                signExt = 1'b1;
            end
            OpSltiu: begin
                aluOp   = AluSltu;
                signExt = 1'b1;   // extended signed, compared unsigned
            end
            OpAndi:  aluOp = AluAnd;
            OpOri:   aluOp = AluOr;
            OpXori:  aluOp = AluXor;
            OpLui:   aluOp = AluLui;
            default: known = 1'b0;
        endcase
    end

    assign immExt = {{(32-ImmW){signExt & imm[ImmW-1]}}, imm};
    assign dest   = destRt ? rt : rd;

    // register file, r0 is never written and reads as zero
    always_ff @(posedge clk) begin
        if (wb.regWrite) begin
            regs[wb.writeReg] <= wb.result;
        end
    end

    assign rdA = (rs == '0) ? '0 : regs[rs];
    assign rdB = (rt == '0) ? '0 : regs[rt];

    assign selA = pickFwd(rs, fwdEx.regWrite, fwdEx.writeReg, wb.regWrite, wb.writeReg);
    assign selB = pickFwd(rt, fwdEx.regWrite, fwdEx.writeReg, wb.regWrite, wb.writeReg);
    assign srcA = fwdMux(selA, rdA, fwdEx.result, wb.result);
    assign srcB = fwdMux(selB, rdB, fwdEx.result, wb.result);

    assign ex.opA      = srcA;
    assign ex.opB      = useImm ? immExt : srcB;
    assign ex.shamt    = instrD[ShamtLsb +: ShamtW];
    assign ex.aluOp    = aluOp;
    assign ex.regWrite = known && (dest != '0);   // unknown or r0 target drops out here
    assign ex.writeReg = dest;
    assign ex.pc       = pcD;

endmodule

// File: rtl/execute_stage.sv
module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,
    input  logic  stall_i,
    decExIf.sink  dec,
    exWbIf.source wb
);

    word_t               opA, opB, pcE, result;
    logic [ShamtW-1:0]   shamt;
    aluOp_e              aluOp;
    logic                regWriteE;
    logic [RegAddrW-1:0] writeRegE;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWriteE <= 1'b0;
        end else if (!stall_i) begin
            regWriteE <= dec.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            opA       <= dec.opA;
            opB       <= dec.opB;
            shamt     <= dec.shamt;
            aluOp     <= dec.aluOp;
            writeRegE <= dec.writeReg;
            pcE       <= dec.pc;
        end
    end

    always_comb begin
        case (aluOp)
            AluAdd:  result = opA + opB;   // wraps, no overflow trap
            AluSub:  result = opA - opB;
            AluAnd:  result = opA & opB;
            AluOr:   result = opA | opB;
            AluXor:  result = opA ^ opB;
            AluNor:  result = ~(opA | opB);
            AluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            AluSltu: result = {31'b0, opA < opB};
            AluSll:  result = opB << shamt;
            AluSrl:  result = opB >> shamt;
            AluLui:  result = {opB[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    assign wb.regWrite = regWriteE;
    assign wb.writeReg = writeRegE;
    assign wb.result   = result;
    assign wb.pc       = pcE;

endmodule

// File: rtl/writeback_stage.sv
module writeback_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst_i,
    input  logic                stall_i,
    exWbIf.sink                 ex,
    wbRfIf.source               rf,
    output word_t               debugWbPc_o,
    output logic [3:0]          debugWbRfWen_o,
    output logic [RegAddrW-1:0] debugWbRfWnum_o,
    output word_t               debugWbRfWdata_o
);

    logic                regWriteW;
    logic [RegAddrW-1:0] writeRegW;
    word_t               resultW, pcW;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWriteW <= 1'b0;
        end else if (!stall_i) begin
            regWriteW <= ex.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            writeRegW <= ex.writeReg;
            resultW   <= ex.result;
            pcW       <= ex.pc;
        end
    end

    // a held instruction writes once, on the cycle the freeze lifts
    assign rf.regWrite = regWriteW & ~stall_i;
    assign rf.writeReg = writeRegW;
    assign rf.result   = resultW;
    assign rf.pc       = pcW;

    assign debugWbPc_o      = rf.pc;
    assign debugWbRfWen_o   = {4{rf.regWrite}};
    assign debugWbRfWnum_o  = rf.writeReg;
    assign debugWbRfWdata_o = rf.result;

endmodule

// File: rtl/mips_core.sv
module mips_core
    import isa_pkg::*, pipe_pkg::*;
#(
    parameter word_t ResetPc = '0
) (
    input  logic                clk,
    input  logic                rst_i,
    // instruction memory, synchronous read
    output word_t               instAddr_o,
    output logic                instEn_o,
    input  word_t               instr_i,
    input  logic                instStall_i,
    // retire trace
    output word_t               debugWbPc_o,
    output logic [3:0]          debugWbRfWen_o,
    output logic [RegAddrW-1:0] debugWbRfWnum_o,
    output word_t               debugWbRfWdata_o
);

    word_t pcF2;
    logic  validF2;

    decExIf decEx ();
    exWbIf  exWb ();
    wbRfIf  wbRf ();

    // the cache stall freezes every stage at once
    fetch_stage #(
        .ResetPc(ResetPc)
    ) fetch (
        .clk       (clk),
        .rst_i     (rst_i),
        .stall_i   (instStall_i),
        .instAddr_o(instAddr_o),
        .instEn_o  (instEn_o),
        .pcF2_o    (pcF2),
        .validF2_o (validF2)
    );

    decode_stage decode (
        .clk      (clk),
        .rst_i    (rst_i),
        .stall_i  (instStall_i),
        .instr_i  (instr_i),
        .pcF2_i   (pcF2),
        .validF2_i(validF2),
        .ex       (decEx.source),
        .fwdEx    (exWb.fwd),
        .wb       (wbRf.sink)
    );

    execute_stage execute (
        .clk    (clk),
        .rst_i  (rst_i),
        .stall_i(instStall_i),
        .dec    (decEx.sink),
        .wb     (exWb.source)
    );

    writeback_stage writeback (
        .clk             (clk),
        .rst_i           (rst_i),
        .stall_i         (instStall_i),
        .ex              (exWb.sink),
        .rf              (wbRf.source),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

endmodule

// File: tb/core_checker.sv
module core_checker
    import isa_pkg::*;
(
    input logic                clk,
    input logic                rst_i,
    input logic                stall_i,
    input logic                instEn_i,
    input logic [3:0]          wen_i,
    input logic [RegAddrW-1:0] wnum_i
);

    int failCount = 0;   // read by the testbench top at the end

    resetQuiet: assert property (@(posedge clk) rst_i |-> wen_i == 4'b0)
        else begin
            failCount++;
            $error("debug write enable high during reset");
        end

    // a frozen writeback must not report
    stallQuiet: assert property (@(posedge clk) stall_i |-> wen_i == 4'b0)
        else begin
            failCount++;
            $error("debug write enable high while stalled");
        end

    fetchHeld: assert property (@(posedge clk) stall_i |-> !instEn_i)
        else begin
            failCount++;
            $error("instruction enable high while stalled");
        end

    noZeroWrite: assert property (@(posedge clk) (wen_i != 4'b0) |-> wnum_i != '0)
        else begin
            failCount++;
            $error("debug write reported for register 0");
        end

endmodule

bind mips_core core_checker checks (
    .clk     (clk),
    .rst_i   (rst_i),
    .stall_i (instStall_i),
    .instEn_i(instEn_o),
    .wen_i   (debugWbRfWen_o),
    .wnum_i  (debugWbRfWnum_o)
);

// File: tb/core_monitor.sv
module core_monitor
    import isa_pkg::*, pipe_pkg::*;
#(
    parameter int    ProgLen = 64,
    parameter word_t ResetPc = '0
) (
    input  logic                clk,
    input  logic                rst_i,
    input  word_t               prog_i [ProgLen],
    input  word_t               debugWbPc_i,
    input  logic [3:0]          debugWbRfWen_i,
    input  logic [RegAddrW-1:0] debugWbRfWnum_i,
    input  word_t               debugWbRfWdata_i,
    output int                  errors_o,
    output int                  pending_o,
    output logic                done_o
);

    word_t               expPc    [$];
    word_t               expInstr [$];
    logic [RegAddrW-1:0] expNum   [$];
    word_t               expData  [$];
    int                  errors  = 0;
    int                  pending = 0;
    logic                built   = 1'b0;

    assign errors_o  = errors;
    assign pending_o = pending;
    assign done_o    = built && (pending == 0);

    // destination of a writing instruction, 0 for no write
    function automatic logic [RegAddrW-1:0] refDest(input word_t instr);
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] rd;
        rt = instr[RtLsb +: RegAddrW];
        rd = instr[RdLsb +: RegAddrW];
        case (instr[OpLsb +: OpW])
            OpSpecial: begin
                case (instr[FunctW-1:0])
                    FnSll, FnSrl, FnAddu, FnSubu, FnAnd,
                    FnOr, FnXor, FnNor, FnSlt, FnSltu: return rd;
                    default: return '0;
                endcase
            end
            OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: return rt;
            default: return '0;   // unknown encoding
        endcase
    endfunction

    function automatic word_t refResult(input word_t instr, input word_t a, input word_t b);
        word_t             sImm;
        word_t             zImm;
        logic [ShamtW-1:0] sh;
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'b0, instr[15:0]};
        sh   = instr[ShamtLsb +: ShamtW];
        case (instr[OpLsb +: OpW])
            OpSpecial: begin
                case (instr[FunctW-1:0])
                    FnAddu:  return a + b;
                    FnSubu:  return a - b;
                    FnAnd:   return a & b;
                    FnOr:    return a | b;
                    FnXor:   return a ^ b;
                    FnNor:   return ~(a | b);
                    FnSlt:   return {31'b0, $signed(a) < $signed(b)};
                    FnSltu:  return {31'b0, a < b};
                    FnSll:   return b << sh;
                    FnSrl:   return b >> sh;
                    default: return '0;
                endcase
            end
            OpAddiu: return a + sImm;
            OpSlti:  return {31'b0, $signed(a) < $signed(sImm)};
            OpSltiu: return {31'b0, a < sImm};   // sign extended, unsigned compare
            OpAndi:  return a & zImm;
            OpOri:   return a | zImm;
            OpXori:  return a ^ zImm;
            OpLui:   return {instr[15:0], 16'b0};
            default: return '0;
        endcase
    endfunction

    function automatic string mnemonic(input word_t instr);
        funct_e  fn;
        opcode_e op;
        fn = funct_e'(instr[FunctW-1:0]);
        op = opcode_e'(instr[OpLsb +: OpW]);
        if (op == OpSpecial) begin
            return fn.name();
        end
        return op.name();
    endfunction

    // run the program in order on a model register file
    task automatic buildExpected();
        word_t               regs [RegCount];
        word_t               instr;
        word_t               value;
        logic [RegAddrW-1:0] dst;
        for (int r = 0; r < RegCount; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < ProgLen; i++) begin
            instr = prog_i[i];
            dst   = refDest(instr);
            value = refResult(instr, regs[instr[RsLsb +: RegAddrW]],
                              regs[instr[RtLsb +: RegAddrW]]);
            if (dst != '0) begin
                regs[dst] = value;
                expPc.push_back(ResetPc + 32'(4 * i));
                expInstr.push_back(instr);
                expNum.push_back(dst);
                expData.push_back(value);
            end
        end
    endtask

    task automatic compareField(input string test, input string field,
                                input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        string test;
        if (rst_i) begin
            if (debugWbRfWen_i != 4'b0) begin
                $display("debug write seen while reset was asserted");
                errors++;
            end
        end else begin
            if (!built) begin
                buildExpected();
                built = 1'b1;
            end
            if (debugWbRfWen_i != 4'b0) begin
                if (debugWbRfWen_i != 4'hf) begin
                    $display("debug write enable bits disagree: %b", debugWbRfWen_i);
                    errors++;
                end
                if (expPc.size() == 0) begin
                    $display("unexpected debug write to r%0d at pc %h",
                             debugWbRfWnum_i, debugWbPc_i);
                    errors++;
                end else begin
                    test = $sformatf("%s@%h", mnemonic(expInstr[0]), expPc[0]);
                    compareField(test, "pc", expPc[0], debugWbPc_i);
                    compareField(test, "wnum", 32'(expNum[0]), 32'(debugWbRfWnum_i));
                    compareField(test, "wdata", expData[0], debugWbRfWdata_i);
                    void'(expPc.pop_front());
                    void'(expInstr.pop_front());
                    void'(expNum.pop_front());
                    void'(expData.pop_front());
                end
            end
        end
        pending = expPc.size();
    end

endmodule

// File: tb/tb_top.sv
module tb_top
    import isa_pkg::*, pipe_pkg::*;
();

    localparam word_t       ResetPc   = 32'h0040_0000;
    localparam int          ProgLen   = 64;
    localparam int          ProgAddrW = $clog2(ProgLen);
    localparam int          ClkPeriod = 4;
    localparam logic [15:0] Seed      = 16'd14812;
    localparam int          TimeLimit = ProgLen * 4 * ClkPeriod + 200;

    logic                clk = 1'b0;
    logic                rst_i;
    word_t               instAddr_o;
    logic                instEn_o;
    word_t               instr_i;
    logic                instStall_i;
    word_t               debugWbPc_o;
    logic [3:0]          debugWbRfWen_o;
    logic [RegAddrW-1:0] debugWbRfWnum_o;
    word_t               debugWbRfWdata_o;

    word_t               prog [ProgLen];
    logic [15:0]         lfsr;
    word_t               fetchAddr;
    logic [RegAddrW-1:0] lastDst [2];
    logic [RegCount-1:0] written;   // registers the program has set so far
    int                  stallLeft;
    int                  errors;
    int                  pending;
    logic                done;

    always #(ClkPeriod / 2) clk = ~clk;

    mips_core #(
        .ResetPc(ResetPc)
    ) u_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .instAddr_o      (instAddr_o),
        .instEn_o        (instEn_o),
        .instr_i         (instr_i),
        .instStall_i     (instStall_i),
        .debugWbPc_o     (debugWbPc_o),
        .debugWbRfWen_o  (debugWbRfWen_o),
        .debugWbRfWnum_o (debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    core_monitor #(
        .ProgLen(ProgLen),
        .ResetPc(ResetPc)
    ) monitor (
        .clk             (clk),
        .rst_i           (rst_i),
        .prog_i          (prog),
        .debugWbPc_i     (debugWbPc_o),
        .debugWbRfWen_i  (debugWbRfWen_o),
        .debugWbRfWnum_i (debugWbRfWnum_o),
        .debugWbRfWdata_i(debugWbRfWdata_o),
        .errors_o        (errors),
        .pending_o       (pending),
        .done_o          (done)
    );

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    // about half the time one of the two most recent destinations
    function automatic logic [RegAddrW-1:0] pickSrc();
        logic [RegAddrW-1:0] r;
        if (stepLfsr()) begin
            r = stepLfsr() ? lastDst[0] : lastDst[1];
        end else begin
            r = RegAddrW'(takeBits(RegAddrW));
            if (!written[r]) begin
                r = '0;   // never read an unset register
            end
        end
        return r;
    endfunction

    function automatic word_t rType(input funct_e fn, input logic [RegAddrW-1:0] s,
                                    input logic [RegAddrW-1:0] t,
                                    input logic [RegAddrW-1:0] d,
                                    input logic [ShamtW-1:0] sh);
        return {OpSpecial, s, t, d, sh, fn};
    endfunction

    function automatic word_t iType(input opcode_e op, input logic [RegAddrW-1:0] s,
                                    input logic [RegAddrW-1:0] t, input logic [ImmW-1:0] imm);
        return {op, s, t, imm};
    endfunction

    task automatic genProgram();
        int                  kind;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] rd;
        logic [ShamtW-1:0]   shamt;
        logic [ImmW-1:0]     imm;
        written    = '0;
        written[0] = 1'b1;
        lastDst[0] = '0;
        lastDst[1] = '0;
        for (int i = 0; i < ProgLen; i++) begin
            // first 17 walk every opcode starting with the immediates
            kind  = (i < 17) ? (i + 10) % 17 : int'(takeBits(5) % 20);
            rs    = pickSrc();
            rt    = pickSrc();
            rd    = RegAddrW'(takeBits(RegAddrW));
            shamt = ShamtW'(takeBits(ShamtW));
            imm   = ImmW'(takeBits(ImmW));
            case (kind)
                0:  prog[i] = rType(FnAddu, rs, rt, rd, '0);
                1:  prog[i] = rType(FnSubu, rs, rt, rd, '0);
                2:  prog[i] = rType(FnAnd, rs, rt, rd, '0);
                3:  prog[i] = rType(FnOr, rs, rt, rd, '0);
                4:  prog[i] = rType(FnXor, rs, rt, rd, '0);
                5:  prog[i] = rType(FnNor, rs, rt, rd, '0);
                6:  prog[i] = rType(FnSlt, rs, rt, rd, '0);
                7:  prog[i] = rType(FnSltu, rs, rt, rd, '0);
                8:  prog[i] = rType(FnSll, '0, rt, rd, shamt);
                9:  prog[i] = rType(FnSrl, '0, rt, rd, shamt);
                10: prog[i] = iType(OpAddiu, rs, rd, imm);
                11: prog[i] = iType(OpSlti, rs, rd, imm);
                12: prog[i] = iType(OpSltiu, rs, rd, imm);
                13: prog[i] = iType(OpAndi, rs, rd, imm);
                14: prog[i] = iType(OpOri, rs, rd, imm);
                15: prog[i] = iType(OpXori, rs, rd, imm);
                16: prog[i] = iType(OpLui, '0, rd, imm);
                17: prog[i] = {6'h23, rs, rt, imm};                  // lw needs the data port
                18: prog[i] = {OpSpecial, rs, rt, rd, 5'd0, 6'h18};  // mult
                default: prog[i] = iType(OpAddiu, rs, '0, imm);      // r0 target
            endcase
            if (kind <= 16 && rd != '0) begin
                lastDst[1]  = lastDst[0];
                lastDst[0]  = rd;
                written[rd] = 1'b1;
            end
        end
    endtask

    function automatic word_t romWord(input word_t addr);
        word_t idx;
        idx = (addr - ResetPc) >> 2;
        return (idx < ProgLen) ? prog[idx[ProgAddrW-1:0]] : '0;
    endfunction

    // ROM latches the address only on enabled cycles so the word holds under stall
    always @(posedge clk) begin
        if (instEn_o) begin
            fetchAddr = instAddr_o;
        end
        #1 instr_i = romWord(fetchAddr);
    end

    task automatic driveStall();
        if (stallLeft != 0) begin
            stallLeft--;
        end
        if (stallLeft == 0 && takeBits(3) == 0) begin
            stallLeft = int'(takeBits(2) % 3) + 1;   // 1 to 3 cycles
        end
        instStall_i = (stallLeft != 0);
    endtask

    initial begin
        rst_i       = 1'b1;
        instStall_i = 1'b0;
        instr_i     = '0;
        fetchAddr   = ResetPc;
        stallLeft   = 0;
        lfsr        = Seed;
        genProgram();
        repeat (4) @(posedge clk);
        #1 rst_i = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1 driveStall();
        end
        instStall_i = 1'b0;
        repeat (8) @(posedge clk);   // catch stray writes after the last one
        $display("errors: %0d mismatches, %0d assertion failures",
                 errors, u_dut.checks.failCount);
        if (errors == 0 && u_dut.checks.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TimeLimit);
        $display("timeout after %0d time units, %0d expected writes never appeared, %0d errors",
                 TimeLimit, pending, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: flist.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mips_core.sv
tb/core_checker.sv
tb/core_monitor.sv
tb/tb_top.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_top
FLIST    := flist.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
RUNARGS  := +verilator+error+limit+1000
PASS_MSG := TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
